// ==== Makefile ====
TOP = ex_stage_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f flist.f --top-module ex_stage

obj_dir/V$(TOP): flist.f src/*.sv verification/*.sv
	verilator --binary --timing --assert -Wno-fatal -j 0 -f flist.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir

// ==== flist.f ====
src/ex_pkg.sv
src/int_alu.sv
src/pipe_mult.sv
src/issue_execute.sv
src/completion_queue.sv
src/writeback_port.sv
src/ex_stage.sv
verification/ex_stage_tb.sv

// ==== src/completion_queue.sv ====
`timescale 1ns/1ps

module completion_queue #(
	parameter int queue_depth = 8
) (
	input  logic            clock,
	input  logic            reset,
	input  ex_pkg::result_t push_first,
	input  ex_pkg::result_t push_second,
	output ex_pkg::result_t head,
	input  logic            pop
);
	import ex_pkg::*;

	localparam int ptr_bits   = (queue_depth > 1) ? $clog2(queue_depth) : 1;
	localparam int count_bits = $clog2(queue_depth + 1);

	tag_t  tags   [queue_depth];
	word_t values [queue_depth];

	logic [ptr_bits-1:0]   head_ptr;
	logic [ptr_bits-1:0]   tail_ptr;
	logic [ptr_bits-1:0]   tail_ptr_next;  // slot after tail
	logic [count_bits-1:0] count;
	logic [1:0]            n_push;
	result_t               lane_a;         // written at tail
	result_t               lane_b;         // written after lane_a

	function automatic logic [ptr_bits-1:0] bump(input logic [ptr_bits-1:0] ptr);
		if (ptr == ptr_bits'(queue_depth - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// compact the lanes, multiplier first
	always_comb begin
		if (push_first.valid) begin
			lane_a = push_first;
			lane_b = push_second;
		end else begin
			lane_a = push_second;
			lane_b = '0;
		end
	end

	assign n_push        = {1'b0, lane_a.valid} + {1'b0, lane_b.valid};
	assign tail_ptr_next = bump(tail_ptr);

	////////////////////////////////////////////////////////////////////////////
	// storage and pointers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (lane_a.valid) begin
			tags[tail_ptr]   <= lane_a.tag;
			values[tail_ptr] <= lane_a.value;
		end
		if (lane_b.valid) begin
			tags[tail_ptr_next]   <= lane_b.tag;
			values[tail_ptr_next] <= lane_b.value;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			head_ptr <= '0;
			tail_ptr <= '0;
			count    <= '0;
		end else begin
			if (pop) begin
				head_ptr <= bump(head_ptr);
			end
			case (n_push)
				2'd1:    tail_ptr <= tail_ptr_next;
				2'd2:    tail_ptr <= bump(tail_ptr_next);
				default: tail_ptr <= tail_ptr;
			endcase
			count <= count + count_bits'(n_push) - count_bits'(pop);
		end
	end

	assign head = '{valid: count != '0, tag: tags[head_ptr], value: values[head_ptr]};

	no_overflow: assert property (@(posedge clock) disable iff (reset)
		count <= count_bits'(queue_depth))
		else $error("completion_queue: occupancy above queue_depth");

	no_empty_pop: assert property (@(posedge clock) disable iff (reset)
		pop |-> count != '0)
		else $error("completion_queue: pop while empty");

endmodule

// ==== src/ex_pkg.sv ====
package ex_pkg;

	////////////////////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////////////////////

	localparam int xlen       = 32;
	localparam int shamt_bits = $clog2(xlen);  // 5 for rv32
	localparam int tag_bits   = 6;

	typedef logic [xlen-1:0]     word_t;
	typedef logic [tag_bits-1:0] tag_t;  // zero means no destination

	////////////////////////////////////////////////////////////////////////////
	// encodings
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		alu_unit,
		mult_unit,
		branch_unit
	} exec_unit_t;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_sltu,
		alu_sll,
		alu_srl,
		alu_sra
	} alu_func_t;

	typedef enum logic {
		opb_is_rs2,
		opb_is_i_imm
	} opb_select_t;

	// branch conditions in funct3
	localparam logic [2:0] funct3_beq  = 3'b000;
	localparam logic [2:0] funct3_bne  = 3'b001;
	localparam logic [2:0] funct3_blt  = 3'b100;
	localparam logic [2:0] funct3_bge  = 3'b101;
	localparam logic [2:0] funct3_bltu = 3'b110;
	localparam logic [2:0] funct3_bgeu = 3'b111;

	// one instruction word, read as r-type or i-type
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i;
	} inst_t;

	typedef struct packed {
		logic        valid;
		exec_unit_t  unit;
		alu_func_t   alu_func;
		opb_select_t opb_select;
		logic        cond_branch;
		logic        uncond_branch;
		word_t       rs1_value;
		word_t       rs2_value;
		inst_t       inst;
		tag_t        dest_tag;
	} issue_packet_t;

	typedef struct packed {
		logic  valid;
		tag_t  tag;
		word_t value;
	} result_t;

endpackage

// ==== src/ex_stage.sv ====
`timescale 1ns/1ps

module ex_stage #(
	parameter int mult_stages = 4,
	parameter int queue_depth = 8
) (
	input  logic                  clock,
	input  logic                  reset,
	input  ex_pkg::issue_packet_t issue,
	output ex_pkg::result_t       complete,
	output logic                  take_branch
);
	import ex_pkg::*;

	result_t mult_result;    // lane one, queued first
	result_t alu_br_result;  // lane two
	result_t queue_head;
	logic    pop;

	issue_execute #(.mult_stages(mult_stages)) execute (
		.clock         (clock),
		.reset         (reset),
		.issue         (issue),
		.mult_result   (mult_result),
		.alu_br_result (alu_br_result),
		.take_branch   (take_branch)
	);

	completion_queue #(.queue_depth(queue_depth)) cqueue (
		.clock       (clock),
		.reset       (reset),
		.push_first  (mult_result),
		.push_second (alu_br_result),
		.head        (queue_head),
		.pop         (pop)
	);

	writeback_port writeback (
		.clock    (clock),
		.reset    (reset),
		.head     (queue_head),
		.pop      (pop),
		.complete (complete)
	);

endmodule

// ==== src/int_alu.sv ====
`timescale 1ns/1ps

module int_alu (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  start,
	input  ex_pkg::issue_packet_t packet,
	output ex_pkg::result_t       result
);
	import ex_pkg::*;

	word_t opa;
	word_t opb;
	word_t i_imm;    // sign-extended i immediate
	word_t alu_out;

	assign opa   = packet.rs1_value;
	assign i_imm = {{(xlen-12){packet.inst.i.imm[11]}}, packet.inst.i.imm};

	always_comb begin
		case (packet.opb_select)
			opb_is_rs2:   opb = packet.rs2_value;
			opb_is_i_imm: opb = i_imm;
			default:      opb = packet.rs2_value;
		endcase
	end

	always_comb begin
		case (packet.alu_func)
			alu_add:  alu_out = opa + opb;
			alu_sub:  alu_out = opa - opb;
			alu_and:  alu_out = opa & opb;
			alu_or:   alu_out = opa | opb;
			alu_xor:  alu_out = opa ^ opb;
			alu_slt:  alu_out = {{(xlen-1){1'b0}}, $signed(opa) < $signed(opb)};
			alu_sltu: alu_out = {{(xlen-1){1'b0}}, opa < opb};
			alu_sll:  alu_out = opa << opb[shamt_bits-1:0];
			alu_srl:  alu_out = opa >> opb[shamt_bits-1:0];
			alu_sra:  alu_out = $signed(opa) >>> opb[shamt_bits-1:0];  // keeps sign
			default:  alu_out = '0;
		endcase
	end

	// one cycle result record
	always_ff @(posedge clock) begin
		if (reset) begin
			result.valid <= 1'b0;
		end else begin
			result.valid <= start;
		end
		result.tag   <= packet.dest_tag;
		result.value <= alu_out;
	end

	func_defined: assert property (@(posedge clock) disable iff (reset)
		start |-> packet.alu_func inside {alu_add, alu_sub, alu_and, alu_or, alu_xor,
			alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra})
		else $error("int_alu: undefined alu_func on start");

endmodule

// ==== src/issue_execute.sv ====
`timescale 1ns/1ps

module issue_execute #(
	parameter int mult_stages = 4
) (
	input  logic                  clock,
	input  logic                  reset,
	input  ex_pkg::issue_packet_t issue,
	output ex_pkg::result_t       mult_result,
	output ex_pkg::result_t       alu_br_result,
	output logic                  take_branch
);
	import ex_pkg::*;

	logic    alu_start;
	logic    mult_start;
	logic    branch_start;
	logic    cond_true;   // condition from funct3
	result_t alu_result;
	result_t br_result;

	// steer by unit
	assign alu_start    = issue.valid && (issue.unit == alu_unit);
	assign mult_start   = issue.valid && (issue.unit == mult_unit);
	assign branch_start = issue.valid && (issue.unit == branch_unit);

	int_alu alu (
		.clock  (clock),
		.reset  (reset),
		.start  (alu_start),
		.packet (issue),
		.result (alu_result)
	);

	pipe_mult #(.mult_stages(mult_stages)) mult (
		.clock  (clock),
		.reset  (reset),
		.start  (mult_start),
		.mcand  (issue.rs1_value),
		.mplier (issue.rs2_value),
		.tag    (issue.dest_tag),
		.result (mult_result)
	);

	////////////////////////////////////////////////////////////////////////////
	// branch condition
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (issue.inst.r.funct3)
			funct3_beq:  cond_true = issue.rs1_value == issue.rs2_value;
			funct3_bne:  cond_true = issue.rs1_value != issue.rs2_value;
			funct3_blt:  cond_true = $signed(issue.rs1_value) < $signed(issue.rs2_value);
			funct3_bge:  cond_true = $signed(issue.rs1_value) >= $signed(issue.rs2_value);
			funct3_bltu: cond_true = issue.rs1_value < issue.rs2_value;
			funct3_bgeu: cond_true = issue.rs1_value >= issue.rs2_value;
			default:     cond_true = 1'b0;
		endcase
	end

	// branches complete with value zero
	always_ff @(posedge clock) begin
		if (reset) begin
			br_result.valid <= 1'b0;
			take_branch     <= 1'b0;
		end else begin
			br_result.valid <= branch_start;
			take_branch     <= branch_start
				&& (issue.uncond_branch || (issue.cond_branch && cond_true));
		end
		br_result.tag   <= issue.dest_tag;
		br_result.value <= '0;
	end

	assign alu_br_result = alu_result.valid ? alu_result : br_result;  // one issue per cycle

	alu_br_exclusive: assert property (@(posedge clock) disable iff (reset)
		!(alu_result.valid && br_result.valid))
		else $error("issue_execute: alu and branch results valid together");

endmodule

// ==== src/pipe_mult.sv ====
`timescale 1ns/1ps

module pipe_mult #(
	parameter int mult_stages = 4
) (
	input  logic            clock,
	input  logic            reset,
	input  logic            start,
	input  ex_pkg::word_t   mcand,
	input  ex_pkg::word_t   mplier,
	input  ex_pkg::tag_t    tag,
	output ex_pkg::result_t result
);
	import ex_pkg::*;

	localparam int slice_bits = xlen / mult_stages;  // multiplier bits per stage
	localparam int pass_regs  = (mult_stages > 1) ? mult_stages - 1 : 1;

	// index s holds what stage s registered
	word_t prod_q   [mult_stages];
	tag_t  tag_q    [mult_stages];
	logic  valid_q  [mult_stages];
	word_t mplier_q [pass_regs];  // multiplier bits still to do
	word_t mcand_q  [pass_regs];  // multiplicand shifted into place

	if (xlen % mult_stages != 0) begin : bad_stage_count
		$error("pipe_mult: mult_stages must divide xlen");
	end

	for (genvar s = 0; s < mult_stages; s++) begin : stage
		word_t prod_in;
		word_t mplier_in;
		word_t mcand_in;
		tag_t  tag_in;
		logic  valid_in;

		if (s == 0) begin : from_ports
			assign prod_in   = '0;
			assign mplier_in = mplier;
			assign mcand_in  = mcand;
			assign tag_in    = tag;
			assign valid_in  = start;
		end else begin : from_prev
			assign prod_in   = prod_q[s-1];
			assign mplier_in = mplier_q[s-1];
			assign mcand_in  = mcand_q[s-1];
			assign tag_in    = tag_q[s-1];
			assign valid_in  = valid_q[s-1];
		end

		always_ff @(posedge clock) begin
			if (reset) begin
				valid_q[s] <= 1'b0;
			end else begin
				valid_q[s] <= valid_in;
			end
			tag_q[s]  <= tag_in;
			prod_q[s] <= prod_in + word_t'(mplier_in[slice_bits-1:0]) * mcand_in;
		end

		// last stage has no one to hand operands to
		if (s < mult_stages - 1) begin : pass
			always_ff @(posedge clock) begin
				mplier_q[s] <= mplier_in >> slice_bits;
				mcand_q[s]  <= mcand_in << slice_bits;
			end
		end
	end

	assign result = '{valid: valid_q[mult_stages-1], tag: tag_q[mult_stages-1],
		value: prod_q[mult_stages-1]};

endmodule

// ==== src/writeback_port.sv ====
`timescale 1ns/1ps

module writeback_port (
	input  logic            clock,
	input  logic            reset,
	input  ex_pkg::result_t head,
	output logic            pop,
	output ex_pkg::result_t complete
);

	// take the head whenever there is one
	assign pop = head.valid;

	// one-cycle broadcast of the popped record
	always_ff @(posedge clock) begin
		if (reset) begin
			complete.valid <= 1'b0;
		end else begin
			complete.valid <= head.valid;  // low when the queue is empty
		end
		complete.tag   <= head.tag;
		complete.value <= head.value;
	end

endmodule

// ==== verification/ex_stage_tb.sv ====
`timescale 1ns/1ps

module ex_stage_tb;
	import ex_pkg::*;

	localparam int mult_stages     = 4;
	localparam int queue_depth     = 8;
	localparam int period          = 4;
	localparam int total_ops       = 206;
	localparam int max_gap         = 3;  // idle cycles between ops at most
	localparam int watchdog_cycles = 8 + total_ops * (max_gap + 1)
		+ 8 * (mult_stages + queue_depth);

	localparam logic [2:0] branch_funct3 [6] = '{funct3_beq, funct3_bne, funct3_blt,
		funct3_bge, funct3_bltu, funct3_bgeu};
	localparam word_t branch_a [3] = '{32'h5, 32'hfffffff0, 32'h5};
	localparam word_t branch_b [3] = '{32'h5, 32'h5, 32'hfffffff0};

	typedef struct packed {
		int    key;    // queue write edge, multiplier lane first
		tag_t  tag;
		word_t value;
	} expect_t;

	logic          clock = 1'b0;
	logic          reset;
	issue_packet_t issue;
	result_t       complete;
	logic          take_branch;

	logic [31:0] lfsr_state = 32'h84408e8b;
	tag_t        free_tags[$];
	expect_t     expected[$];  // in completion order
	int          issued    = 0;
	int          completed = 0;
	int          cycle     = 0;
	logic        take_due  = 1'b0;

	ex_stage #(.mult_stages(mult_stages), .queue_depth(queue_depth)) UUT (
		.clock       (clock),
		.reset       (reset),
		.issue       (issue),
		.complete    (complete),
		.take_branch (take_branch)
	);

	initial begin
		forever #(period / 2) clock = ~clock;
	end

	initial begin
		#(watchdog_cycles * period);
		abort_run("watchdog timeout before all operations completed");
	end

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic word_t random_bits(int n);
		word_t bits;
		bits = '0;
		for (int b = 0; b < n; b++) begin
			bits = {bits[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h80200003 : lfsr_state >> 1;
		end
		return bits;
	endfunction

	function automatic word_t pick_operand();
		case (random_bits(3))
			0:       return '0;
			1:       return 32'h80000000;
			2:       return 32'hffffffff;
			3:       return 32'h7fffffff;
			4:       return random_bits(5);  // small, for shift amounts
			default: return random_bits(32);
		endcase
	endfunction

	function automatic word_t expected_result(issue_packet_t p);
		word_t a;
		word_t b;
		int    sh;
		a  = p.rs1_value;
		b  = (p.opb_select == opb_is_i_imm) ? {{20{p.inst.i.imm[11]}}, p.inst.i.imm}
			: p.rs2_value;
		sh = int'(b[4:0]);
		if (p.unit == mult_unit) begin
			return p.rs1_value * p.rs2_value;  // low word only
		end
		if (p.unit == branch_unit) begin
			return '0;
		end
		case (p.alu_func)
			alu_add:  return a + b;
			alu_sub:  return a + ~b + 32'd1;
			alu_and:  return a & b;
			alu_or:   return a | b;
			alu_xor:  return a ^ b;
			alu_slt:  return word_t'((a ^ 32'h80000000) < (b ^ 32'h80000000));
			alu_sltu: return word_t'(a < b);
			alu_sll:  return a << sh;
			alu_srl:  return a >> sh;
			alu_sra:  return (a >> sh) | (a[31] ? ~(32'hffffffff >> sh) : 32'h0);
			default:  return '0;
		endcase
	endfunction

	function automatic logic branch_taken(issue_packet_t p);
		logic lt_signed;
		logic lt_unsigned;
		logic cond;
		lt_signed   = (p.rs1_value ^ 32'h80000000) < (p.rs2_value ^ 32'h80000000);
		lt_unsigned = p.rs1_value < p.rs2_value;
		case (p.inst.r.funct3)
			funct3_beq:  cond = p.rs1_value == p.rs2_value;
			funct3_bne:  cond = p.rs1_value != p.rs2_value;
			funct3_blt:  cond = lt_signed;
			funct3_bge:  cond = !lt_signed;
			funct3_bltu: cond = lt_unsigned;
			funct3_bgeu: cond = !lt_unsigned;
			default:     cond = 1'b0;
		endcase
		return p.uncond_branch || (p.cond_branch && cond);
	endfunction

	task automatic abort_run(string what);
		$display("%s", what);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check_value(string name, word_t actual, word_t expected_value);
		if (actual !== expected_value) begin
			$display("error at %0t: %s is %h, expected %h", $time, name, actual,
				expected_value);
			$display("Something failed");
			$fatal(1);
		end
	endtask

	task automatic send_op(exec_unit_t unit, alu_func_t func, opb_select_t opb, logic cond,
		logic uncond, word_t rs1, word_t rs2, word_t inst_word);
		issue_packet_t pkt;
		@(posedge clock);
		while (free_tags.size() == 0) begin
			issue.valid <= 1'b0;
			@(posedge clock);
		end
		pkt = '{valid: 1'b1, unit: unit, alu_func: func, opb_select: opb, cond_branch: cond,
			uncond_branch: uncond, rs1_value: rs1, rs2_value: rs2, inst: inst_word,
			dest_tag: free_tags.pop_front()};
		issue <= pkt;
	endtask

	task automatic idle(int n);
		repeat (n) begin
			@(posedge clock);
			issue.valid <= 1'b0;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// monitor and scoreboard
	////////////////////////////////////////////////////////////////////////////

	initial begin
		expect_t item;
		int      pos;
		logic    is_mult;
		forever begin
			@(negedge clock);
			cycle++;
			if (reset) begin
				check_value("complete.valid", word_t'(complete.valid), '0);
				check_value("take_branch", word_t'(take_branch), '0);
			end else begin
				check_value("take_branch", word_t'(take_branch), word_t'(take_due));
				if (complete.valid && expected.size() == 0) begin
					abort_run("a result completed with no operation in flight");
				end else if (complete.valid) begin
					item = expected.pop_front();
					check_value("complete.tag", word_t'(complete.tag), word_t'(item.tag));
					check_value("complete.value", complete.value, item.value);
					free_tags.push_back(complete.tag);
					completed++;
				end
				take_due = 1'b0;
				if (issue.valid) begin  // sampled at the next rising edge
					is_mult    = issue.unit == mult_unit;
					item.key   = 2 * (cycle + (is_mult ? mult_stages : 1)) + (is_mult ? 0 : 1);
					item.tag   = issue.dest_tag;
					item.value = expected_result(issue);
					pos        = expected.size();
					while (pos > 0 && expected[pos-1].key > item.key) begin
						pos--;
					end
					expected.insert(pos, item);
					take_due = (issue.unit == branch_unit) && branch_taken(issue);
					issued++;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin
		reset = 1'b1;
		issue = '0;
		for (int t = 1; t < 2**tag_bits; t++) begin
			free_tags.push_back(tag_t'(t));
		end
		repeat (8) @(posedge clock);
		reset <= 1'b0;

		// every alu function, register and immediate operand b
		for (int f = 0; f < 10; f++) begin
			for (int k = 0; k < 8; k++) begin
				send_op(alu_unit, alu_func_t'(4'(f)), opb_select_t'(1'(k % 2)), 1'b0, 1'b0,
					pick_operand(), pick_operand(), random_bits(12) << 20);
				idle(int'(random_bits(2)));
			end
		end

		// multiplies back to back, pipeline full
		send_op(mult_unit, alu_add, opb_is_rs2, 1'b0, 1'b0, 32'hffffffff, 32'hffffffff, '0);
		send_op(mult_unit, alu_add, opb_is_rs2, 1'b0, 1'b0, 32'h80000000, 32'h2, '0);
		send_op(mult_unit, alu_add, opb_is_rs2, 1'b0, 1'b0, 32'h12345678, 32'h0, '0);
		send_op(mult_unit, alu_add, opb_is_rs2, 1'b0, 1'b0, 32'hffffffff, 32'h1, '0);
		repeat (24) begin
			send_op(mult_unit, alu_add, opb_is_rs2, 1'b0, 1'b0, random_bits(32),
				random_bits(32), '0);
		end

		// each condition taken and not taken
		for (int j = 0; j < 6; j++) begin
			for (int k = 0; k < 3; k++) begin
				send_op(branch_unit, alu_add, opb_is_rs2, 1'b1, 1'b0, branch_a[k], branch_b[k],
					word_t'(branch_funct3[j]) << 12);
				idle(int'(random_bits(1)));
			end
		end
		repeat (4) begin
			send_op(branch_unit, alu_add, opb_is_rs2, 1'b0, 1'b1, random_bits(32),
				random_bits(32), random_bits(3) << 12);
		end

		// alu op lands in the same cycle as the multiply ahead of it
		repeat (4) begin
			send_op(mult_unit, alu_add, opb_is_rs2, 1'b0, 1'b0, random_bits(32),
				random_bits(32), '0);
			repeat (3) begin
				send_op(alu_unit, alu_add, opb_is_rs2, 1'b0, 1'b0, random_bits(32),
					random_bits(32), '0);
			end
		end

		// mixed traffic
		repeat (60) begin
			case (random_bits(2) % 3)
				0: send_op(alu_unit, alu_func_t'(4'(random_bits(4) % 10)),
					opb_select_t'(1'(random_bits(1))), 1'b0, 1'b0, pick_operand(),
					pick_operand(), random_bits(12) << 20);
				1: send_op(mult_unit, alu_add, opb_is_rs2, 1'b0, 1'b0, pick_operand(),
					pick_operand(), '0);
				default: send_op(branch_unit, alu_add, opb_is_rs2, 1'b1,
					1'(random_bits(1)), pick_operand(), pick_operand(),
					word_t'(branch_funct3[random_bits(3) % 6]) << 12);
			endcase
			idle(int'(random_bits(2)));
		end

		idle(1);
		while (completed < issued) begin
			@(posedge clock);
		end
		repeat (mult_stages + queue_depth) @(posedge clock);  // nothing may follow
		if (expected.size() != 0 || completed != total_ops) begin
			abort_run("not every issued operation completed exactly once");
		end else begin
			$display("Everything OK");
			$finish;
		end
	end

endmodule
